/* logic/backend_consts.svh */
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// datapath widths
`define XLEN 64
`define INSTR_W 32

// architectural register file
`define AREG_W 5
`define NUM_REG 32

// issue queue sizing, pointer width is log2 of depth
`define IQ_DEPTH 4
`define IQ_PTR_W 2

`endif

/* logic/backend_pkg.sv */
`include "backend_consts.svh"

package backend_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`AREG_W-1:0] areg_t;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // control transfer kind, resolved in the integer block
    typedef enum logic [1:0] {
        CX_NONE,
        CX_BEQ,
        CX_BNE,
        CX_JAL
    } cx_type_e;

endpackage

/* logic/ctrlblock.sv */
`include "backend_consts.svh"

module ctrlblock (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        ibuffer_instr_valid,
    input  logic [`INSTR_W-1:0]         ibuffer_inst_out,
    input  backend_pkg::xlen_t          ibuffer_pc_out,
    output logic                        ibuffer_ready,
    input  logic                        iq_can_alloc,
    input  logic                        redirect_valid,
    output logic                        enq_valid,
    output backend_pkg::areg_t          enq_rs1,
    output backend_pkg::areg_t          enq_rs2,
    output backend_pkg::areg_t          enq_rd,
    output logic                        enq_src1_is_reg,
    output logic                        enq_src2_is_reg,
    output logic                        enq_need_to_wb,
    output backend_pkg::alu_op_e        enq_alu_type,
    output backend_pkg::cx_type_e       enq_cx_type,
    output logic                        enq_is_imm,
    output backend_pkg::xlen_t          enq_imm,
    output backend_pkg::xlen_t          enq_pc
);

    import backend_pkg::*;

    logic [`INSTR_W-1:0] inst;
    opcode_e             opcode;
    logic [2:0]          funct3;
    xlen_t               imm_i;
    xlen_t               imm_u;
    xlen_t               imm_j;
    xlen_t               imm_b;
    alu_op_e             alu_f3;
    logic                alu_ok;
    logic                out_of_reset;

    assign inst   = ibuffer_inst_out;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    // sign-extended immediates
    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // funct3 map shared by OP and OP_IMM
    always_comb begin
        alu_ok = 1'b1;
        case (funct3)
            3'b000: alu_f3 = ALU_ADD;
            3'b111: alu_f3 = ALU_AND;
            3'b110: alu_f3 = ALU_OR;
            3'b100: alu_f3 = ALU_XOR;
            3'b010: alu_f3 = ALU_SLT;
            default: begin
                alu_f3 = ALU_ADD;
                alu_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        enq_src1_is_reg = 1'b0;
        enq_src2_is_reg = 1'b0;
        enq_need_to_wb  = 1'b0;
        enq_alu_type    = ALU_ADD;
        enq_cx_type     = CX_NONE;
        enq_is_imm      = 1'b0;
        enq_imm         = '0;
        case (opcode)
            OPC_OP: begin
                enq_src1_is_reg = 1'b1;
                enq_src2_is_reg = 1'b1;
                enq_need_to_wb  = alu_ok;
                enq_alu_type    = (funct3 == 3'b000 && inst[30]) ? ALU_SUB : alu_f3;
            end
            OPC_OP_IMM: begin
                enq_src1_is_reg = 1'b1;
                enq_need_to_wb  = alu_ok;
                enq_alu_type    = alu_f3;
                enq_is_imm      = 1'b1;
                enq_imm         = imm_i;
            end
            OPC_LUI: begin
                enq_need_to_wb = 1'b1;
                enq_alu_type   = ALU_PASS_B;
                enq_is_imm     = 1'b1;
                enq_imm        = imm_u;
            end
            OPC_JAL: begin
                enq_need_to_wb = 1'b1;
                enq_cx_type    = CX_JAL;
                enq_is_imm     = 1'b1;
                enq_imm        = imm_j;
            end
            OPC_BRANCH: begin
                // other branch kinds decode to a no-op
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    enq_src1_is_reg = 1'b1;
                    enq_src2_is_reg = 1'b1;
                    enq_cx_type     = (funct3 == 3'b000) ? CX_BEQ : CX_BNE;
                end
                enq_imm = imm_b;
            end
            default: begin
                enq_imm = '0;
            end
        endcase
    end

    // unused index fields are zeroed so the scoreboard never sees them
    assign enq_rs1 = enq_src1_is_reg ? areg_t'(inst[19:15]) : '0;
    assign enq_rs2 = enq_src2_is_reg ? areg_t'(inst[24:20]) : '0;
    assign enq_rd  = enq_need_to_wb ? areg_t'(inst[11:7]) : '0;
    assign enq_pc  = ibuffer_pc_out;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    assign ibuffer_ready = out_of_reset & iq_can_alloc & ~redirect_valid;
    assign enq_valid     = ibuffer_instr_valid & ibuffer_ready;

    // a redirect blocks dispatch for a single cycle
    a_redirect_is_pulse: assert property (
        @(posedge clock) disable iff (!rst_n) redirect_valid |=> !redirect_valid
    );

endmodule

/* logic/issuequeue.sv */
`include "backend_consts.svh"

module issuequeue #(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  logic                    clock,
    input  logic                    rst_n,
    output logic                    iq_can_alloc,
    input  logic                    enq_valid,
    input  backend_pkg::areg_t      enq_rs1,
    input  backend_pkg::areg_t      enq_rs2,
    input  backend_pkg::areg_t      enq_rd,
    input  logic                    enq_src1_is_reg,
    input  logic                    enq_src2_is_reg,
    input  logic                    enq_need_to_wb,
    input  backend_pkg::alu_op_e    enq_alu_type,
    input  backend_pkg::cx_type_e   enq_cx_type,
    input  logic                    enq_is_imm,
    input  backend_pkg::xlen_t      enq_imm,
    input  backend_pkg::xlen_t      enq_pc,
    output logic                    deq_valid,
    output backend_pkg::areg_t      deq_rs1,
    output backend_pkg::areg_t      deq_rs2,
    output backend_pkg::areg_t      deq_rd,
    output logic                    deq_src1_is_reg,
    output logic                    deq_src2_is_reg,
    output logic                    deq_need_to_wb,
    output backend_pkg::alu_op_e    deq_alu_type,
    output backend_pkg::cx_type_e   deq_cx_type,
    output logic                    deq_is_imm,
    output backend_pkg::xlen_t      deq_imm,
    output backend_pkg::xlen_t      deq_pc,
    input  logic                    writeback_valid,
    input  logic                    writeback_need_to_wb,
    input  backend_pkg::areg_t      writeback_rd,
    input  logic                    flush_valid
);

    import backend_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    typedef struct packed {
        areg_t    rs1;
        areg_t    rs2;
        areg_t    rd;
        logic     src1_is_reg;
        logic     src2_is_reg;
        logic     need_to_wb;
        alu_op_e  alu_type;
        cx_type_e cx_type;
        logic     is_imm;
        xlen_t    imm;
        xlen_t    pc;
    } entry_t;

    entry_t             entries [DEPTH];
    entry_t             head_entry;
    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   tail_q;
    logic [PTR_W:0]     count_q;
    logic [`NUM_REG-1:0] busy_q;
    logic [`NUM_REG-1:0] busy_next;
    logic               src_ready;

    assign iq_can_alloc = (count_q != DEPTH);
    assign head_entry   = entries[head_q];

    // rd busy also blocks issue so an older writeback cannot wake a newer writer
    assign src_ready = ~(head_entry.src1_is_reg & busy_q[head_entry.rs1])
                     & ~(head_entry.src2_is_reg & busy_q[head_entry.rs2])
                     & ~(head_entry.need_to_wb & busy_q[head_entry.rd]);
    assign deq_valid = (count_q != '0) & src_ready & ~flush_valid;

    assign deq_rs1         = head_entry.rs1;
    assign deq_rs2         = head_entry.rs2;
    assign deq_rd          = head_entry.rd;
    assign deq_src1_is_reg = head_entry.src1_is_reg;
    assign deq_src2_is_reg = head_entry.src2_is_reg;
    assign deq_need_to_wb  = head_entry.need_to_wb;
    assign deq_alu_type    = head_entry.alu_type;
    assign deq_cx_type     = head_entry.cx_type;
    assign deq_is_imm      = head_entry.is_imm;
    assign deq_imm         = head_entry.imm;
    assign deq_pc          = head_entry.pc;

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            entries[tail_q] <= '{enq_rs1, enq_rs2, enq_rd, enq_src1_is_reg, enq_src2_is_reg,
                                 enq_need_to_wb, enq_alu_type, enq_cx_type, enq_is_imm,
                                 enq_imm, enq_pc};
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_valid) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (enq_valid) begin
                tail_q <= tail_q + 1'b1;
            end
            if (deq_valid) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(enq_valid) - (PTR_W+1)'(deq_valid);
        end
    end

    // scoreboard, set on issue wins over writeback clear
    always_comb begin
        busy_next = busy_q;
        if (writeback_valid && writeback_need_to_wb) begin
            busy_next[writeback_rd] = 1'b0;
        end
        if (deq_valid && deq_need_to_wb && deq_rd != '0) begin
            busy_next[deq_rd] = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else if (flush_valid) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_next;
        end
    end

    a_no_enq_when_full: assert property (
        @(posedge clock) disable iff (!rst_n) enq_valid |-> (count_q != DEPTH)
    );

endmodule

/* logic/regfile.sv */
`include "backend_consts.svh"

module regfile (
    input  logic               clock,
    input  logic               rst_n,
    input  backend_pkg::areg_t read0_idx,
    input  backend_pkg::areg_t read1_idx,
    output backend_pkg::xlen_t read0_data,
    output backend_pkg::xlen_t read1_data,
    input  logic               write_en,
    input  backend_pkg::areg_t write_idx,
    input  backend_pkg::xlen_t write_data
);

    import backend_pkg::*;

    xlen_t regs [`NUM_REG];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != '0) begin
            regs[write_idx] <= write_data;
        end
    end

    // x0 is hardwired
    assign read0_data = (read0_idx == '0) ? '0 : regs[read0_idx];
    assign read1_data = (read1_idx == '0) ? '0 : regs[read1_idx];

endmodule

/* logic/intblock.sv */
`include "backend_consts.svh"

module intblock (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  backend_pkg::areg_t      rd,
    input  backend_pkg::xlen_t      src1,
    input  backend_pkg::xlen_t      src2,
    input  backend_pkg::xlen_t      imm,
    input  backend_pkg::xlen_t      pc,
    input  logic                    need_to_wb,
    input  backend_pkg::alu_op_e    alu_type,
    input  backend_pkg::cx_type_e   cx_type,
    input  logic                    is_imm,
    input  logic                    flush_valid,
    output logic                    out_instr_valid,
    output logic                    out_need_to_wb,
    output backend_pkg::areg_t      out_rd,
    output backend_pkg::xlen_t      out_result,
    output logic                    out_redirect_valid,
    output backend_pkg::xlen_t      out_redirect_target
);

    import backend_pkg::*;

    xlen_t opb;
    xlen_t alu_result;
    xlen_t result;
    logic  taken;

    assign opb = is_imm ? imm : src2;

    always_comb begin
        case (alu_type)
            ALU_SUB:    alu_result = src1 - opb;
            ALU_AND:    alu_result = src1 & opb;
            ALU_OR:     alu_result = src1 | opb;
            ALU_XOR:    alu_result = src1 ^ opb;
            ALU_SLT:    alu_result = xlen_t'($signed(src1) < $signed(opb));
            ALU_PASS_B: alu_result = opb;
            default:    alu_result = src1 + opb;
        endcase
    end

    // branch resolution
    always_comb begin
        case (cx_type)
            CX_BEQ:  taken = (src1 == src2);
            CX_BNE:  taken = (src1 != src2);
            CX_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jal links the return address
    assign result = (cx_type == CX_JAL) ? pc + xlen_t'(4) : alu_result;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_instr_valid    <= 1'b0;
            out_redirect_valid <= 1'b0;
        end else begin
            out_instr_valid    <= instr_valid & ~flush_valid;
            out_redirect_valid <= instr_valid & ~flush_valid & taken;
        end
    end

    always_ff @(posedge clock) begin
        out_need_to_wb      <= need_to_wb;
        out_rd              <= rd;
        out_result          <= result;
        out_redirect_target <= pc + imm;
    end

    // the issue queue holds back issue while a flush is active
    a_no_issue_in_flush: assert property (
        @(posedge clock) disable iff (!rst_n) flush_valid |-> !instr_valid
    );

endmodule

/* logic/backend.sv */
`include "backend_consts.svh"

module backend (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                ibuffer_instr_valid,
    output logic                ibuffer_ready,
    input  logic [`INSTR_W-1:0] ibuffer_inst_out,
    input  backend_pkg::xlen_t  ibuffer_pc_out,
    output logic                redirect_valid,
    output backend_pkg::xlen_t  redirect_target,
    output logic                wb_valid,
    output backend_pkg::areg_t  wb_rd,
    output backend_pkg::xlen_t  wb_result
);

    import backend_pkg::*;

    // dispatch toward the issue queue
    logic     iq_can_alloc;
    logic     enq_valid;
    areg_t    enq_rs1;
    areg_t    enq_rs2;
    areg_t    enq_rd;
    logic     enq_src1_is_reg;
    logic     enq_src2_is_reg;
    logic     enq_need_to_wb;
    alu_op_e  enq_alu_type;
    cx_type_e enq_cx_type;
    logic     enq_is_imm;
    xlen_t    enq_imm;
    xlen_t    enq_pc;

    // issued instruction
    logic     deq_valid;
    areg_t    deq_rs1;
    areg_t    deq_rs2;
    areg_t    deq_rd;
    logic     deq_need_to_wb;
    alu_op_e  deq_alu_type;
    cx_type_e deq_cx_type;
    logic     deq_is_imm;
    xlen_t    deq_imm;
    xlen_t    deq_pc;
    xlen_t    deq_src1;
    xlen_t    deq_src2;

    // execute output
    logic     int_out_instr_valid;
    logic     int_out_need_to_wb;
    areg_t    int_out_rd;
    xlen_t    int_out_result;
    logic     int_out_redirect_valid;
    xlen_t    int_out_redirect_target;

    // writeback stage
    logic     writeback_valid;
    logic     writeback_need_to_wb;
    areg_t    writeback_rd;
    xlen_t    writeback_result;

    ctrlblock u_ctrlblock (
        .clock               (clock),
        .rst_n               (rst_n),
        .ibuffer_instr_valid (ibuffer_instr_valid),
        .ibuffer_inst_out    (ibuffer_inst_out),
        .ibuffer_pc_out      (ibuffer_pc_out),
        .ibuffer_ready       (ibuffer_ready),
        .iq_can_alloc        (iq_can_alloc),
        .redirect_valid      (redirect_valid),
        .enq_valid           (enq_valid),
        .enq_rs1             (enq_rs1),
        .enq_rs2             (enq_rs2),
        .enq_rd              (enq_rd),
        .enq_src1_is_reg     (enq_src1_is_reg),
        .enq_src2_is_reg     (enq_src2_is_reg),
        .enq_need_to_wb      (enq_need_to_wb),
        .enq_alu_type        (enq_alu_type),
        .enq_cx_type         (enq_cx_type),
        .enq_is_imm          (enq_is_imm),
        .enq_imm             (enq_imm),
        .enq_pc              (enq_pc)
    );

    issuequeue #(
        .DEPTH(`IQ_DEPTH)
    ) u_issuequeue (
        .clock                (clock),
        .rst_n                (rst_n),
        .iq_can_alloc         (iq_can_alloc),
        .enq_valid            (enq_valid),
        .enq_rs1              (enq_rs1),
        .enq_rs2              (enq_rs2),
        .enq_rd               (enq_rd),
        .enq_src1_is_reg      (enq_src1_is_reg),
        .enq_src2_is_reg      (enq_src2_is_reg),
        .enq_need_to_wb       (enq_need_to_wb),
        .enq_alu_type         (enq_alu_type),
        .enq_cx_type          (enq_cx_type),
        .enq_is_imm           (enq_is_imm),
        .enq_imm              (enq_imm),
        .enq_pc               (enq_pc),
        .deq_valid            (deq_valid),
        .deq_rs1              (deq_rs1),
        .deq_rs2              (deq_rs2),
        .deq_rd               (deq_rd),
        .deq_src1_is_reg      (),
        .deq_src2_is_reg      (),
        .deq_need_to_wb       (deq_need_to_wb),
        .deq_alu_type         (deq_alu_type),
        .deq_cx_type          (deq_cx_type),
        .deq_is_imm           (deq_is_imm),
        .deq_imm              (deq_imm),
        .deq_pc               (deq_pc),
        .writeback_valid      (writeback_valid),
        .writeback_need_to_wb (writeback_need_to_wb),
        .writeback_rd         (writeback_rd),
        .flush_valid          (redirect_valid)
    );

    regfile u_regfile (
        .clock      (clock),
        .rst_n      (rst_n),
        .read0_idx  (deq_rs1),
        .read1_idx  (deq_rs2),
        .read0_data (deq_src1),
        .read1_data (deq_src2),
        .write_en   (writeback_valid & writeback_need_to_wb),
        .write_idx  (writeback_rd),
        .write_data (writeback_result)
    );

    intblock u_intblock (
        .clock               (clock),
        .rst_n               (rst_n),
        .instr_valid         (deq_valid),
        .rd                  (deq_rd),
        .src1                (deq_src1),
        .src2                (deq_src2),
        .imm                 (deq_imm),
        .pc                  (deq_pc),
        .need_to_wb          (deq_need_to_wb),
        .alu_type            (deq_alu_type),
        .cx_type             (deq_cx_type),
        .is_imm              (deq_is_imm),
        .flush_valid         (redirect_valid),
        .out_instr_valid     (int_out_instr_valid),
        .out_need_to_wb      (int_out_need_to_wb),
        .out_rd              (int_out_rd),
        .out_result          (int_out_result),
        .out_redirect_valid  (int_out_redirect_valid),
        .out_redirect_target (int_out_redirect_target)
    );

    // the instruction right behind a taken branch is dropped here
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            writeback_valid <= 1'b0;
            redirect_valid  <= 1'b0;
        end else begin
            writeback_valid <= int_out_instr_valid & ~redirect_valid;
            redirect_valid  <= int_out_redirect_valid & ~redirect_valid;
        end
    end

    always_ff @(posedge clock) begin
        writeback_need_to_wb <= int_out_need_to_wb;
        writeback_rd         <= int_out_rd;
        writeback_result     <= int_out_result;
        redirect_target      <= int_out_redirect_target;
    end

    // trace port hides writes to x0
    assign wb_valid  = writeback_valid & writeback_need_to_wb & (writeback_rd != '0);
    assign wb_rd     = writeback_rd;
    assign wb_result = writeback_result;

endmodule

/* verification/clock_gen.sv */
module clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

/* verification/tb_backend.sv */
module tb_backend;

    typedef enum int {
        K_ADDI,
        K_ADD,
        K_SUB,
        K_AND,
        K_OR,
        K_XOR,
        K_SLT,
        K_LUI,
        K_JAL,
        K_BEQ,
        K_BNE
    } kind_e;

    logic        clock;
    logic        rst_n;
    logic        ibuffer_instr_valid;
    logic        ibuffer_ready;
    logic [31:0] ibuffer_inst_out;
    logic [63:0] ibuffer_pc_out;
    logic        redirect_valid;
    logic [63:0] redirect_target;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_result;

    // architectural state of the reference model
    logic [63:0] model_regs [32];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_result [$];
    logic [63:0] exp_target [$];
    logic [63:0] pc_q;
    logic [63:0] branch_target;
    int          driven_count;
    int          cycle_count;
    int          stall_cycles;

    clock_gen #(
        .PERIOD       (40),
        .RESET_CYCLES (8)
    ) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    backend i_dut (
        .clock               (clock),
        .rst_n               (rst_n),
        .ibuffer_instr_valid (ibuffer_instr_valid),
        .ibuffer_ready       (ibuffer_ready),
        .ibuffer_inst_out    (ibuffer_inst_out),
        .ibuffer_pc_out      (ibuffer_pc_out),
        .redirect_valid      (redirect_valid),
        .redirect_target     (redirect_target),
        .wb_valid            (wb_valid),
        .wb_rd               (wb_rd),
        .wb_result           (wb_result)
    );

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic end_with_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [63:0] rand_imm12();
        logic [11:0] r;
        r = 12'($urandom);
        return {{52{r[11]}}, r};
    endfunction

    function automatic logic [63:0] rand_upper();
        logic [19:0] u;
        u = 20'($urandom);
        return {{32{u[19]}}, u, 12'h000};
    endfunction

    // RV64I encodings of the kept instructions
    function automatic logic [31:0] encode(input kind_e kind, input int rd, input int rs1,
                                           input int rs2, input logic [63:0] imm);
        logic [4:0] d;
        logic [4:0] s1;
        logic [4:0] s2;
        d  = 5'(rd);
        s1 = 5'(rs1);
        s2 = 5'(rs2);
        case (kind)
            K_ADDI:  return {imm[11:0], s1, 3'b000, d, 7'b0010011};
            K_ADD:   return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
            K_SUB:   return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
            K_AND:   return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
            K_OR:    return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
            K_XOR:   return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
            K_SLT:   return {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
            K_LUI:   return {imm[31:12], d, 7'b0110111};
            K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'b1101111};
            K_BEQ:   return {imm[12], imm[10:5], s2, s1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:   return {imm[12], imm[10:5], s2, s1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            default: return 32'h0000_0013;
        endcase
    endfunction

    // executes one instruction and queues the expected trace
    task automatic model_exec(input kind_e kind, input int rd, input int rs1, input int rs2,
                              input logic [63:0] imm, output bit taken);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] res;
        bit          writes;
        a      = model_regs[rs1];
        b      = model_regs[rs2];
        writes = 1'b1;
        taken  = 1'b0;
        res    = '0;
        case (kind)
            K_ADDI: res = a + imm;
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            K_LUI:  res = imm;
            K_JAL: begin
                res   = pc_q + 64'd4;
                taken = 1'b1;
            end
            K_BEQ: begin
                writes = 1'b0;
                taken  = (a == b);
            end
            default: begin
                writes = 1'b0;
                taken  = (a != b);
            end
        endcase
        if (writes && rd != 0) begin
            model_regs[rd] = res;
            exp_rd.push_back(5'(rd));
            exp_result.push_back(res);
        end
        if (taken) begin
            branch_target = pc_q + imm;
            exp_target.push_back(branch_target);
        end
    endtask

    // holds the word from a falling edge until the falling edge after acceptance
    task automatic drive_word(input logic [31:0] word, input logic [63:0] pc);
        driven_count++;
        ibuffer_instr_valid = 1'b1;
        ibuffer_inst_out    = word;
        ibuffer_pc_out      = pc;
        while (!ibuffer_ready) begin
            stall_cycles++;
            @(negedge clock);
        end
        @(negedge clock);
        ibuffer_instr_valid = 1'b0;
    endtask

    task automatic send_instr(input kind_e kind, input int rd, input int rs1, input int rs2,
                              input logic [63:0] imm);
        bit taken;
        model_exec(kind, rd, rs1, rs2, imm, taken);
        drive_word(encode(kind, rd, rs1, rs2, imm), pc_q);
        pc_q = pc_q + 64'd4;
    endtask

    // wrong-path fill until the redirect pulse
    // none of it may retire
    task automatic run_shadow();
        int k;
        k = 0;
        while (!redirect_valid) begin
            if (k > 20) begin
                end_with_failure("redirect_valid never pulsed after a taken branch");
            end
            ibuffer_instr_valid = 1'b1;
            ibuffer_inst_out    = encode(K_ADDI, 24 + k % 4, 0, 0, 64'(1440 + k));
            ibuffer_pc_out      = pc_q;
            if (ibuffer_ready) begin
                k++;
                driven_count++;
                pc_q = pc_q + 64'd4;
            end
            @(negedge clock);
        end
        ibuffer_instr_valid = 1'b0;
        if (k == 0) begin
            end_with_failure("no instruction was accepted behind the taken branch");
        end
        pc_q = branch_target;
    endtask

    task automatic wait_drain();
        while (exp_rd.size() != 0 || exp_target.size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic independent_alu();
        send_instr(K_ADDI, 1, 0, 0, rand_imm12());
        send_instr(K_ADDI, 2, 0, 0, rand_imm12());
        send_instr(K_LUI, 3, 0, 0, rand_upper());
        // x0 destination gives nothing on the trace port
        send_instr(K_ADDI, 0, 0, 0, 64'd5);
        send_instr(K_LUI, 4, 0, 0, rand_upper());
        wait_drain();
        send_instr(K_AND, 5, 1, 2, '0);
        send_instr(K_OR, 6, 1, 3, '0);
        send_instr(K_XOR, 7, 2, 4, '0);
        send_instr(K_ADDI, 0, 7, 0, rand_imm12());
        wait_drain();
    endtask

    task automatic dependent_chain();
        send_instr(K_ADDI, 8, 0, 0, rand_imm12());
        send_instr(K_ADD, 9, 8, 8, '0);
        send_instr(K_SUB, 10, 9, 1, '0);
        send_instr(K_SLT, 11, 10, 9, '0);
        send_instr(K_SLT, 12, 9, 10, '0);
        send_instr(K_ADD, 13, 11, 12, '0);
        send_instr(K_SUB, 8, 13, 8, '0);
        wait_drain();
    endtask

    task automatic taken_branches();
        send_instr(K_ADDI, 14, 0, 0, 64'd7);
        send_instr(K_ADDI, 15, 0, 0, 64'd7);
        send_instr(K_BEQ, 0, 14, 15, 64'd16);
        run_shadow();
        send_instr(K_BNE, 0, 14, 0, -64'sd8);
        run_shadow();
        send_instr(K_JAL, 16, 0, 0, 64'd2048);
        run_shadow();
        // link value must be visible on the redirected path
        send_instr(K_ADD, 17, 16, 14, '0);
        wait_drain();
    endtask

    task automatic not_taken_branches();
        send_instr(K_BEQ, 0, 14, 0, 64'd32);
        send_instr(K_BNE, 0, 14, 15, 64'd64);
        send_instr(K_ADDI, 18, 14, 0, rand_imm12());
        send_instr(K_ADD, 19, 18, 16, '0);
        wait_drain();
    endtask

    task automatic queue_backpressure();
        int stalls_before;
        stalls_before = stall_cycles;
        send_instr(K_ADDI, 20, 0, 0, 64'd1);
        send_instr(K_ADDI, 21, 0, 0, rand_imm12());
        for (int i = 0; i < 12; i++) begin
            send_instr(K_ADD, 20, 20, 21, '0);
        end
        wait_drain();
        if (stall_cycles == stalls_before) begin
            end_with_failure("ibuffer_ready never dropped while the issue queue was full");
        end
    endtask

    // compares the writeback and redirect trace mid-cycle
    always @(negedge clock) begin
        if (rst_n) begin
            if (wb_valid) begin
                if (exp_rd.size() == 0) begin
                    end_with_failure("writeback seen with no instruction left to retire");
                end
                check_value("wb_rd", 64'(wb_rd), 64'(exp_rd.pop_front()));
                check_value("wb_result", wb_result, exp_result.pop_front());
            end
            if (redirect_valid) begin
                if (exp_target.size() == 0) begin
                    end_with_failure("redirect_valid pulsed with no taken branch pending");
                end
                check_value("redirect_target", redirect_target, exp_target.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > 200 + 40 * driven_count) begin
            end_with_failure("timeout, the DUT stopped making progress");
        end
    end

    initial begin
        ibuffer_instr_valid = 1'b0;
        ibuffer_inst_out    = '0;
        ibuffer_pc_out      = '0;
        pc_q                = 64'h0000_0000_8000_0000;
        branch_target       = '0;
        driven_count        = 0;
        cycle_count         = 0;
        stall_cycles        = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(47));
        repeat (3) @(negedge clock);
        check_value("ibuffer_ready", 64'(ibuffer_ready), 64'd0);
        check_value("wb_valid", 64'(wb_valid), 64'd0);
        check_value("redirect_valid", 64'(redirect_valid), 64'd0);
        wait (rst_n === 1'b1);
        @(negedge clock);
        independent_alu();
        dependent_chain();
        taken_branches();
        not_taken_branches();
        queue_backpressure();
        // quiet tail catches late writebacks from squashed instructions
        repeat (10) @(negedge clock);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/backend_pkg.sv
logic/ctrlblock.sv
logic/issuequeue.sv
logic/regfile.sv
logic/intblock.sv
logic/backend.sv
verification/clock_gen.sv
verification/tb_backend.sv

/* Bender.yml */
package:
  name: int_backend

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/backend_pkg.sv
      - logic/ctrlblock.sv
      - logic/issuequeue.sv
      - logic/regfile.sv
      - logic/intblock.sv
      - logic/backend.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/tb_backend.sv
